// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the register block testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timescale 1ns/1ps -f sources.f --top-module tb_cl_hello -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"

// ==== source/cl_hello_top.sv ====
`timescale 1ns/1ps

module cl_hello_top (
  input  logic               clk_main_a0,
  input  logic               rst_main_n_sync,
  // Write channels
  input  logic               awvalid,
  input  ocl_pkg::ocl_addr_t awaddr,
  output logic               awready,
  input  logic               wvalid,
  input  ocl_pkg::ocl_data_t wdata,
  output logic               wready,
  output logic               bvalid,
  output ocl_pkg::ocl_resp_t bresp,
  input  logic               bready,
  // Read channels
  input  logic               arvalid,
  input  ocl_pkg::ocl_addr_t araddr,
  output logic               arready,
  output logic               rvalid,
  output ocl_pkg::ocl_data_t rdata,
  output ocl_pkg::ocl_resp_t rresp,
  input  logic               rready,
  // Virtual switches and LEDs
  input  ocl_pkg::led_t      vdip,
  output ocl_pkg::led_t      vled
);

  import ocl_pkg::*;

  // FSM to register block
  logic      reg_wr_en;
  ocl_addr_t reg_wr_addr;
  ocl_addr_t reg_rd_addr;
  ocl_data_t reg_rd_data;

  // Register block to counter and back
  logic  cnt_enable;
  logic  cnt_load;
  logic  cnt_clear;
  logic  cnt_oneshot;
  tick_t tick_value;
  cnt_t  load_value;
  cnt_t  watermark;
  cnt_t  count;
  tick_t tick_count;
  logic  ge_watermark;

  // --------------------
  // Bus slave
  // --------------------
  ocl_slave_fsm u_fsm (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wready          (wready),
    .bready          (bready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rready          (rready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .reg_wr_en       (reg_wr_en),
    .reg_wr_addr     (reg_wr_addr),
    .reg_rd_addr     (reg_rd_addr),
    .reg_rd_data     (reg_rd_data)
  );

  // --------------------
  // Registers and LEDs
  // --------------------
  ocl_regs u_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr_en       (reg_wr_en),
    .reg_wr_addr     (reg_wr_addr),
    .wdata           (wdata),
    .reg_rd_addr     (reg_rd_addr),
    .reg_rd_data     (reg_rd_data),
    .vdip            (vdip),
    .vled            (vled),
    .cnt_enable      (cnt_enable),
    .cnt_load        (cnt_load),
    .cnt_clear       (cnt_clear),
    .cnt_oneshot     (cnt_oneshot),
    .tick_value      (tick_value),
    .load_value      (load_value),
    .watermark       (watermark),
    .count           (count),
    .tick_count      (tick_count),
    .ge_watermark    (ge_watermark)
  );

  // Event counter
  tick_counter u_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cnt_enable      (cnt_enable),
    .cnt_load        (cnt_load),
    .cnt_clear       (cnt_clear),
    .cnt_oneshot     (cnt_oneshot),
    .tick_value      (tick_value),
    .load_value      (load_value),
    .watermark       (watermark),
    .count           (count),
    .tick_count      (tick_count),
    .ge_watermark    (ge_watermark)
  );

endmodule

// ==== source/ocl_defines.svh ====
`ifndef OCL_DEFINES_SVH
`define OCL_DEFINES_SVH

// --------------------
// Register map
// --------------------

// Hello-world word, read back byte-swapped
`define HELLO_WORLD_REG_ADDR    32'h0000_0500
// LED shadow, read only
`define VLED_REG_ADDR           32'h0000_0504
// Counter control levels
`define CNT_CTRL_REG_ADDR       32'h0000_0508
// Prescaler terminal value
`define TICK_VALUE_REG_ADDR     32'h0000_050C
`define CNT_LOAD_REG_ADDR       32'h0000_0510
`define CNT_WATERMARK_REG_ADDR  32'h0000_0514
// Count, tick count and watermark flag
`define CNT_STATUS_REG_ADDR     32'h0000_0518

// Returned for any unmapped read
`define UNIMPLEMENTED_REG_VALUE 32'hDEAD_DEAD

// --------------------
// Control register bits
// --------------------
`define CTRL_ENABLE_BIT  0
`define CTRL_LOAD_BIT    1
`define CTRL_CLEAR_BIT   2
`define CTRL_ONESHOT_BIT 3
`define CTRL_WIDTH       4

`endif

// ==== source/ocl_pkg.sv ====
package ocl_pkg;

  // --------------------
  // Bus words
  // --------------------

  // Byte address on the register bus
  typedef logic [31:0] ocl_addr_t;
  // Single-beat data word
  typedef logic [31:0] ocl_data_t;
  // Response code, only OKAY is ever returned
  typedef logic [1:0]  ocl_resp_t;

  // --------------------
  // Data path widths
  // --------------------

  // Virtual LED and DIP switch vector
  typedef logic [15:0] led_t;
  // Event count, load value and watermark
  typedef logic [15:0] cnt_t;
  // Prescaler terminal value and running tick count
  typedef logic [7:0]  tick_t;

  // --------------------
  // Bus state machines
  // --------------------

  // Write side, address then data then response
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_t;

  // Read side, address then mux fetch then response
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_FETCH,
    RD_RESP
  } rd_state_t;

endpackage

// ==== source/ocl_regs.sv ====
`timescale 1ns/1ps

`include "ocl_defines.svh"

module ocl_regs (
  input  logic               clk_main_a0,
  input  logic               rst_main_n_sync,
  // Access from the bus FSM
  input  logic               reg_wr_en,
  input  ocl_pkg::ocl_addr_t reg_wr_addr,
  input  ocl_pkg::ocl_data_t wdata,
  input  ocl_pkg::ocl_addr_t reg_rd_addr,
  output ocl_pkg::ocl_data_t reg_rd_data,
  // Virtual switches and LEDs
  input  ocl_pkg::led_t      vdip,
  output ocl_pkg::led_t      vled,
  // Counter control
  output logic               cnt_enable,
  output logic               cnt_load,
  output logic               cnt_clear,
  output logic               cnt_oneshot,
  output ocl_pkg::tick_t     tick_value,
  output ocl_pkg::cnt_t      load_value,
  output ocl_pkg::cnt_t      watermark,
  // Counter status
  input  ocl_pkg::cnt_t      count,
  input  ocl_pkg::tick_t     tick_count,
  input  logic               ge_watermark
);

  import ocl_pkg::*;

  ocl_data_t               hello_q;
  ocl_data_t               hello_swapped;
  logic [`CTRL_WIDTH-1:0]  ctrl_q;
  ocl_data_t               status_word;

  // DIP synchronizer stages and LED shadow
  led_t vdip_meta;
  led_t vdip_sync;
  led_t led_shadow;

  // --------------------
  // Write decode
  // --------------------

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q    <= '0;
      ctrl_q     <= '0;
      tick_value <= '0;
      load_value <= '0;
      watermark  <= '0;
    end else if (reg_wr_en) begin
      // Full-word writes only
      case (reg_wr_addr)
        `HELLO_WORLD_REG_ADDR:   hello_q    <= wdata;
        `CNT_CTRL_REG_ADDR:      ctrl_q     <= wdata[`CTRL_WIDTH-1:0];
        `TICK_VALUE_REG_ADDR:    tick_value <= wdata[$bits(tick_t)-1:0];
        `CNT_LOAD_REG_ADDR:      load_value <= wdata[$bits(cnt_t)-1:0];
        `CNT_WATERMARK_REG_ADDR: watermark  <= wdata[$bits(cnt_t)-1:0];
        // LED and status are read only
        default: ;
      endcase
    end
  end

  // Control levels straight to the counter
  assign cnt_enable  = ctrl_q[`CTRL_ENABLE_BIT];
  assign cnt_load    = ctrl_q[`CTRL_LOAD_BIT];
  assign cnt_clear   = ctrl_q[`CTRL_CLEAR_BIT];
  assign cnt_oneshot = ctrl_q[`CTRL_ONESHOT_BIT];

  // --------------------
  // Read mux
  // --------------------

  // Byte order reversed on readback
  assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  // Flag in bit 24, tick count above the event count
  assign status_word = {7'b0, ge_watermark, tick_count, count};

  always_comb begin
    case (reg_rd_addr)
      `HELLO_WORLD_REG_ADDR: reg_rd_data = hello_swapped;
      `VLED_REG_ADDR:        reg_rd_data = ocl_data_t'(led_shadow);
      `CNT_STATUS_REG_ADDR:  reg_rd_data = status_word;
      default:               reg_rd_data = `UNIMPLEMENTED_REG_VALUE;
    endcase
  end

  // --------------------
  // LED path
  // --------------------

  // Two flops for the asynchronous DIP inputs
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_meta <= '0;
      vdip_sync <= '0;
    end else begin
      vdip_meta <= vdip;
      vdip_sync <= vdip_meta;
    end
  end

  // Shadow of the low half, then masked by the switches
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      led_shadow <= '0;
      vled       <= '0;
    end else begin
      led_shadow <= hello_q[15:0];
      vled       <= led_shadow & vdip_sync;
    end
  end

endmodule

// ==== source/ocl_slave_fsm.sv ====
`timescale 1ns/1ps

module ocl_slave_fsm (
  input  logic               clk_main_a0,
  input  logic               rst_main_n_sync,
  // Write address channel
  input  logic               awvalid,
  input  ocl_pkg::ocl_addr_t awaddr,
  output logic               awready,
  // Write data channel
  input  logic               wvalid,
  output logic               wready,
  // Write response channel
  input  logic               bready,
  output logic               bvalid,
  output ocl_pkg::ocl_resp_t bresp,
  // Read address channel
  input  logic               arvalid,
  input  ocl_pkg::ocl_addr_t araddr,
  output logic               arready,
  // Read data channel
  input  logic               rready,
  output logic               rvalid,
  output ocl_pkg::ocl_data_t rdata,
  output ocl_pkg::ocl_resp_t rresp,
  // Register block side
  output logic               reg_wr_en,
  output ocl_pkg::ocl_addr_t reg_wr_addr,
  output ocl_pkg::ocl_addr_t reg_rd_addr,
  input  ocl_pkg::ocl_data_t reg_rd_data
);

  import ocl_pkg::*;

  wr_state_t wr_state;
  wr_state_t wr_state_nxt;
  rd_state_t rd_state;
  rd_state_t rd_state_nxt;

  // Latched addresses
  ocl_addr_t wr_addr_q;
  ocl_addr_t rd_addr_q;

  // --------------------
  // Write side
  // --------------------

  always_comb begin
    wr_state_nxt = wr_state;
    case (wr_state)
      WR_IDLE: begin
        if (awvalid) begin
          wr_state_nxt = WR_DATA;
        end
      end
      // Data beat is the register write strobe
      WR_DATA: begin
        if (wvalid) begin
          wr_state_nxt = WR_RESP;
        end
      end
      // Hold bvalid until the master takes it
      WR_RESP: begin
        if (bready) begin
          wr_state_nxt = WR_IDLE;
        end
      end
      default: wr_state_nxt = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_state <= WR_IDLE;
    end else begin
      wr_state <= wr_state_nxt;
    end
  end

  // Address captured on the aw handshake
  always_ff @(posedge clk_main_a0) begin
    if (awvalid && awready) begin
      wr_addr_q <= awaddr;
    end
  end

  assign awready     = (wr_state == WR_IDLE);
  assign wready      = (wr_state == WR_DATA) && wvalid;
  assign bvalid      = (wr_state == WR_RESP);
  assign bresp       = '0;
  // One cycle per accepted data beat
  assign reg_wr_en   = wready;
  assign reg_wr_addr = wr_addr_q;

  // --------------------
  // Read side
  // --------------------

  always_comb begin
    rd_state_nxt = rd_state;
    case (rd_state)
      RD_IDLE: begin
        if (arvalid) begin
          rd_state_nxt = RD_FETCH;
        end
      end
      // Mux output sampled here, always one cycle
      RD_FETCH: rd_state_nxt = RD_RESP;
      RD_RESP: begin
        if (rready) begin
          rd_state_nxt = RD_IDLE;
        end
      end
      default: rd_state_nxt = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_state <= RD_IDLE;
    end else begin
      rd_state <= rd_state_nxt;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (arvalid && arready) begin
      rd_addr_q <= araddr;
    end
  end

  // Read data held through the response, zero once taken
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rdata <= '0;
    end else if (rd_state == RD_FETCH) begin
      rdata <= reg_rd_data;
    end else if (rvalid && rready) begin
      rdata <= '0;
    end
  end

  assign arready     = (rd_state == RD_IDLE);
  assign rvalid      = (rd_state == RD_RESP);
  assign rresp       = '0;
  assign reg_rd_addr = rd_addr_q;

endmodule

// ==== source/tick_counter.sv ====
`timescale 1ns/1ps

module tick_counter (
  input  logic           clk_main_a0,
  input  logic           rst_main_n_sync,
  // Control levels
  input  logic           cnt_enable,
  input  logic           cnt_load,
  input  logic           cnt_clear,
  input  logic           cnt_oneshot,
  input  ocl_pkg::tick_t tick_value,
  input  ocl_pkg::cnt_t  load_value,
  input  ocl_pkg::cnt_t  watermark,
  // Status
  output ocl_pkg::cnt_t  count,
  output ocl_pkg::tick_t tick_count,
  output logic           ge_watermark
);

  import ocl_pkg::*;

  logic  tick_wrap;
  logic  cnt_hold;
  tick_t tick_next;
  cnt_t  count_next;

  // Prescaler terminal reached this cycle
  assign tick_wrap = (tick_count >= tick_value);

  // One-shot stops at all ones instead of rolling over
  assign cnt_hold = cnt_oneshot && (&count);

  always_comb begin
    tick_next  = tick_count;
    count_next = count;
    if (cnt_clear) begin
      // Clear beats load
      tick_next  = '0;
      count_next = '0;
    end else begin
      if (cnt_enable) begin
        tick_next = tick_wrap ? '0 : tick_count + 1'b1;
      end
      if (cnt_load) begin
        count_next = load_value;
      end else if (cnt_enable && tick_wrap && !cnt_hold) begin
        count_next = count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_count   <= '0;
      count        <= '0;
      ge_watermark <= 1'b0;
    end else begin
      tick_count   <= tick_next;
      count        <= count_next;
      // Compared against the current count, so one edge behind
      ge_watermark <= (count >= watermark);
    end
  end

endmodule

// ==== sources.f ====
+incdir+source
source/ocl_pkg.sv
source/ocl_slave_fsm.sv
source/ocl_regs.sv
source/tick_counter.sv
source/cl_hello_top.sv
tb/ocl_checker.sv
tb/tb_cl_hello.sv

// ==== tb/ocl_checker.sv ====
`timescale 1ns/1ps

module ocl_checker (
  input  logic               clk_main_a0,
  input  logic               rst_main_n_sync,
  // DUT outputs and the handshake inputs beside them
  input  logic               awready,
  input  logic               wready,
  input  logic               arready,
  input  logic               bvalid,
  input  logic               bready,
  input  ocl_pkg::ocl_resp_t bresp,
  input  logic               rvalid,
  input  logic               rready,
  input  ocl_pkg::ocl_data_t rdata,
  input  ocl_pkg::ocl_resp_t rresp,
  input  ocl_pkg::led_t      vled,
  // Expected values from the stimulus side
  input  logic               check_rd,
  input  logic               exp_differ,
  input  ocl_pkg::ocl_data_t exp_rdata,
  input  ocl_pkg::ocl_data_t exp_mask,
  input  logic               check_vled,
  input  ocl_pkg::led_t      exp_vled,
  // Error counts
  output int                 rd_errors,
  output int                 vled_errors,
  output int                 other_errors
);

  import ocl_pkg::*;

  int   rd_cnt = 0;
  int   vled_cnt = 0;
  int   other_cnt = 0;
  logic reset_checked = 1'b0;
  logic rd_taken = 1'b0;

  assign rd_errors    = rd_cnt;
  assign vled_errors  = vled_cnt;
  assign other_errors = other_cnt;

  // Exact compare for responses and idle levels
  task automatic compare_other(input string sig, input ocl_data_t expv, input ocl_data_t got);
    if (got !== expv) begin
      $display("Error: time %0t signal %s expected %h got %h", $time, sig, expv, got);
      other_cnt++;
    end
  endtask

  always @(posedge clk_main_a0) begin
    // --------------------
    // Idle state on the first edge out of reset
    // --------------------
    if (rst_main_n_sync && !reset_checked) begin
      reset_checked <= 1'b1;
      compare_other("awready", 32'd1, ocl_data_t'(awready));
      compare_other("arready", 32'd1, ocl_data_t'(arready));
      compare_other("wready", '0, ocl_data_t'(wready));
      compare_other("bvalid", '0, ocl_data_t'(bvalid));
      compare_other("rvalid", '0, ocl_data_t'(rvalid));
      compare_other("vled", '0, ocl_data_t'(vled));
      compare_other("rdata", '0, rdata);
    end

    // --------------------
    // Read data
    // --------------------
    if (rvalid && rready && check_rd) begin
      if (exp_differ) begin
        // Counter must have moved since the earlier read
        if ((rdata & exp_mask) == (exp_rdata & exp_mask)) begin
          $display("Error: time %0t signal rdata expected a value other than %h got %h",
                   $time, exp_rdata & exp_mask, rdata & exp_mask);
          rd_cnt++;
        end
      end else if ((rdata & exp_mask) !== (exp_rdata & exp_mask)) begin
        $display("Error: time %0t signal rdata expected %h got %h",
                 $time, exp_rdata & exp_mask, rdata & exp_mask);
        rd_cnt++;
      end
    end

    // Responses are always OKAY
    if (rvalid && rready) begin
      compare_other("rresp", '0, ocl_data_t'(rresp));
    end
    if (bvalid && bready) begin
      compare_other("bresp", '0, ocl_data_t'(bresp));
    end

    // rdata back to zero once taken
    if (rd_taken) begin
      compare_other("rdata", '0, rdata);
    end
    rd_taken <= rvalid && rready;

    // Masked LED output
    if (check_vled && (vled !== exp_vled)) begin
      $display("Error: time %0t signal vled expected %h got %h", $time, exp_vled, vled);
      vled_cnt++;
    end
  end

endmodule

// ==== tb/tb_cl_hello.sv ====
`timescale 1ns/1ps

`include "ocl_defines.svh"

module tb_cl_hello;

  import ocl_pkg::*;

  localparam int MAX_ROWS = 64;
  localparam int HS_LIMIT = 100;
  // Table operations
  localparam int OP_WRITE = 0;
  localparam int OP_READ  = 1;
  localparam int OP_KEEP  = 2;
  localparam int OP_DIFF  = 3;
  localparam int OP_VDIP  = 4;
  localparam int OP_VLED  = 5;
  localparam int OP_WAIT  = 6;
  // Bus channels
  localparam int CH_AW = 0;
  localparam int CH_W  = 1;
  localparam int CH_B  = 2;
  localparam int CH_AR = 3;
  localparam int CH_R  = 4;
  // Compare masks
  localparam ocl_data_t ALL_BITS = 32'hFFFF_FFFF;
  localparam ocl_data_t CNT_BITS = 32'h0000_FFFF;
  localparam ocl_data_t WM_FLAG  = 32'h0100_0000;

  logic      clk_main_a0;
  logic      rst_main_n_sync;
  logic      awvalid;
  ocl_addr_t awaddr;
  logic      awready;
  logic      wvalid;
  ocl_data_t wdata;
  logic      wready;
  logic      bvalid;
  ocl_resp_t bresp;
  logic      bready;
  logic      arvalid;
  ocl_addr_t araddr;
  logic      arready;
  logic      rvalid;
  ocl_data_t rdata;
  ocl_resp_t rresp;
  logic      rready;
  led_t      vdip;
  led_t      vled;

  // Checker side
  logic      check_rd;
  logic      exp_differ;
  ocl_data_t exp_rdata;
  ocl_data_t exp_mask;
  logic      check_vled;
  led_t      exp_vled;
  int        rd_errors;
  int        vled_errors;
  int        other_errors;
  int        hs_errors;

  // Stimulus table
  int        tbl_op   [MAX_ROWS];
  ocl_addr_t tbl_addr [MAX_ROWS];
  ocl_data_t tbl_data [MAX_ROWS];
  ocl_data_t tbl_exp  [MAX_ROWS];
  ocl_data_t tbl_mask [MAX_ROWS];
  int        n_rows;
  logic      table_ready;
  // Most recent word read back
  ocl_data_t last_rd;

  cl_hello_top UUT (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .vdip            (vdip),
    .vled            (vled)
  );

  ocl_checker u_checker (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awready         (awready),
    .wready          (wready),
    .arready         (arready),
    .bvalid          (bvalid),
    .bready          (bready),
    .bresp           (bresp),
    .rvalid          (rvalid),
    .rready          (rready),
    .rdata           (rdata),
    .rresp           (rresp),
    .vled            (vled),
    .check_rd        (check_rd),
    .exp_differ      (exp_differ),
    .exp_rdata       (exp_rdata),
    .exp_mask        (exp_mask),
    .check_vled      (check_vled),
    .exp_vled        (exp_vled),
    .rd_errors       (rd_errors),
    .vled_errors     (vled_errors),
    .other_errors    (other_errors)
  );

  initial begin
    clk_main_a0 = 1'b0;
    forever #20 clk_main_a0 = ~clk_main_a0;
  end

  // Byte b of the readback is byte 3-b of the written word
  function automatic ocl_data_t byte_swap(input ocl_data_t w);
    ocl_data_t r;
    for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = w[8*(3-b) +: 8];
    end
    return r;
  endfunction

  function automatic logic chan_done(input int ch);
    case (ch)
      CH_AW:   return awready;
      CH_W:    return wready;
      CH_B:    return bvalid;
      CH_AR:   return arready;
      default: return rvalid;
    endcase
  endfunction

  task automatic add_row(input int op, input ocl_addr_t addr, input ocl_data_t data,
                         input ocl_data_t expv, input ocl_data_t mask);
    tbl_op[n_rows]   = op;
    tbl_addr[n_rows] = addr;
    tbl_data[n_rows] = data;
    tbl_exp[n_rows]  = expv;
    tbl_mask[n_rows] = mask;
    n_rows++;
  endtask

  // --------------------
  // Bus tasks, entered 2 ns after an edge
  // --------------------

  // Sampled on the rising edge, gives up after HS_LIMIT cycles
  task automatic wait_chan(input int ch, input string what);
    int n;
    n = 0;
    @(posedge clk_main_a0);
    while (!chan_done(ch) && n < HS_LIMIT) begin
      @(posedge clk_main_a0);
      n++;
    end
    if (!chan_done(ch)) begin
      $display("Timeout: the %s handshake did not complete by time %0t", what, $time);
      hs_errors++;
    end
  endtask

  task automatic bus_write(input ocl_addr_t addr, input ocl_data_t data);
    int hold;
    hold    = $urandom_range(3, 0);
    awvalid = 1'b1;
    awaddr  = addr;
    wait_chan(CH_AW, "write address");
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b1;
    wdata   = data;
    wait_chan(CH_W, "write data");
    #2;
    wvalid = 1'b0;
    // Response back-pressure
    wait_chan(CH_B, "write response");
    repeat (hold) @(posedge clk_main_a0);
    #2;
    bready = 1'b1;
    @(posedge clk_main_a0);
    #2;
    bready = 1'b0;
  endtask

  task automatic bus_read(input ocl_addr_t addr, input logic check, input logic differ,
                          input ocl_data_t expv, input ocl_data_t mask,
                          output ocl_data_t data);
    int hold;
    hold    = $urandom_range(3, 0);
    arvalid = 1'b1;
    araddr  = addr;
    wait_chan(CH_AR, "read address");
    #2;
    arvalid = 1'b0;
    wait_chan(CH_R, "read data");
    repeat (hold) @(posedge clk_main_a0);
    #2;
    rready     = 1'b1;
    check_rd   = check;
    exp_differ = differ;
    exp_rdata  = expv;
    exp_mask   = mask;
    // rdata held steady while rvalid waits
    data       = rdata;
    // Handshake edge, checker compares here
    @(posedge clk_main_a0);
    #2;
    rready   = 1'b0;
    check_rd = 1'b0;
  endtask

  task automatic vled_check(input led_t expv);
    check_vled = 1'b1;
    exp_vled   = expv;
    @(posedge clk_main_a0);
    #2;
    check_vled = 1'b0;
  endtask

  // --------------------
  // Stimulus table
  // --------------------
  task automatic build_table();
    ocl_data_t hw0;
    ocl_data_t hw1;
    hw0    = $urandom();
    hw1    = $urandom();
    n_rows = 0;
    // Hello-world byte swap
    add_row(OP_WRITE, `HELLO_WORLD_REG_ADDR, hw0, '0, '0);
    add_row(OP_READ, `HELLO_WORLD_REG_ADDR, '0, byte_swap(hw0), ALL_BITS);
    add_row(OP_WRITE, `HELLO_WORLD_REG_ADDR, hw1, '0, '0);
    add_row(OP_READ, `HELLO_WORLD_REG_ADDR, '0, byte_swap(hw1), ALL_BITS);
    // Unmapped and LED shadow reads
    add_row(OP_READ, 32'h0000_0600, '0, `UNIMPLEMENTED_REG_VALUE, ALL_BITS);
    add_row(OP_READ, 32'h0000_051C, '0, `UNIMPLEMENTED_REG_VALUE, ALL_BITS);
    add_row(OP_READ, `VLED_REG_ADDR, '0, {16'h0, hw1[15:0]}, ALL_BITS);
    // LEDs masked by the DIP switches
    add_row(OP_VDIP, '0, 32'h0000_F0F0, '0, '0);
    add_row(OP_WAIT, '0, 32'd4, '0, '0);
    add_row(OP_VLED, '0, '0, {16'h0, hw1[15:0] & 16'hF0F0}, '0);
    add_row(OP_VDIP, '0, 32'h0000_3C5A, '0, '0);
    add_row(OP_WAIT, '0, 32'd4, '0, '0);
    add_row(OP_VLED, '0, '0, {16'h0, hw1[15:0] & 16'h3C5A}, '0);
    // Load, then clear from the loaded value
    add_row(OP_WRITE, `CNT_LOAD_REG_ADDR, 32'h0000_1234, '0, '0);
    add_row(OP_WRITE, `CNT_CTRL_REG_ADDR, ocl_data_t'(1 << `CTRL_LOAD_BIT), '0, '0);
    add_row(OP_READ, `CNT_STATUS_REG_ADDR, '0, 32'h0000_1234, CNT_BITS);
    add_row(OP_WRITE, `CNT_CTRL_REG_ADDR, ocl_data_t'(1 << `CTRL_CLEAR_BIT), '0, '0);
    add_row(OP_READ, `CNT_STATUS_REG_ADDR, '0, 32'h0000_0000, CNT_BITS);
    // Reload and hold for the watermark compare
    add_row(OP_WRITE, `CNT_CTRL_REG_ADDR, ocl_data_t'(1 << `CTRL_LOAD_BIT), '0, '0);
    // Watermark below, then above the held count
    add_row(OP_WRITE, `CNT_WATERMARK_REG_ADDR, 32'h0000_1000, '0, '0);
    add_row(OP_READ, `CNT_STATUS_REG_ADDR, '0, WM_FLAG, WM_FLAG);
    add_row(OP_WRITE, `CNT_WATERMARK_REG_ADDR, 32'h0000_2000, '0, '0);
    add_row(OP_READ, `CNT_STATUS_REG_ADDR, '0, 32'h0000_0000, WM_FLAG);
    // One-shot from FFF0 with no prescale, saturates
    add_row(OP_WRITE, `CNT_LOAD_REG_ADDR, 32'h0000_FFF0, '0, '0);
    add_row(OP_WRITE, `TICK_VALUE_REG_ADDR, 32'h0000_0000, '0, '0);
    add_row(OP_WRITE, `CNT_CTRL_REG_ADDR,
            ocl_data_t'((1 << `CTRL_ENABLE_BIT) | (1 << `CTRL_ONESHOT_BIT)), '0, '0);
    add_row(OP_WAIT, '0, 32'd64, '0, '0);
    add_row(OP_READ, `CNT_STATUS_REG_ADDR, '0, 32'h0000_FFFF, CNT_BITS);
    // Free running, count must move
    add_row(OP_WRITE, `TICK_VALUE_REG_ADDR, 32'h0000_0003, '0, '0);
    add_row(OP_WRITE, `CNT_CTRL_REG_ADDR, ocl_data_t'(1 << `CTRL_ENABLE_BIT), '0, '0);
    add_row(OP_KEEP, `CNT_STATUS_REG_ADDR, '0, '0, '0);
    add_row(OP_WAIT, '0, 32'd50, '0, '0);
    add_row(OP_DIFF, `CNT_STATUS_REG_ADDR, '0, '0, CNT_BITS);
  endtask

  task automatic apply_row(input int i);
    case (tbl_op[i])
      OP_WRITE: bus_write(tbl_addr[i], tbl_data[i]);
      OP_READ:  bus_read(tbl_addr[i], 1'b1, 1'b0, tbl_exp[i], tbl_mask[i], last_rd);
      OP_KEEP:  bus_read(tbl_addr[i], 1'b0, 1'b0, '0, '0, last_rd);
      OP_DIFF:  bus_read(tbl_addr[i], 1'b1, 1'b1, last_rd, tbl_mask[i], last_rd);
      OP_VDIP:  vdip = tbl_data[i][15:0];
      OP_VLED:  vled_check(tbl_exp[i][15:0]);
      default: begin
        repeat (tbl_data[i]) @(posedge clk_main_a0);
        #2;
      end
    endcase
  endtask

  task automatic end_run(input logic timed_out);
    int total;
    total = rd_errors + vled_errors + other_errors + hs_errors;
    $display("Summary: rdata errors %0d, vled errors %0d, other errors %0d, timeouts %0d",
             rd_errors, vled_errors, other_errors, hs_errors);
    if (!timed_out && total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    void'($urandom(32'hffa));
    rst_main_n_sync = 1'b0;
    awvalid         = 1'b0;
    awaddr          = '0;
    wvalid          = 1'b0;
    wdata           = '0;
    bready          = 1'b0;
    arvalid         = 1'b0;
    araddr          = '0;
    rready          = 1'b0;
    vdip            = '0;
    check_rd        = 1'b0;
    exp_differ      = 1'b0;
    exp_rdata       = '0;
    exp_mask        = '0;
    check_vled      = 1'b0;
    exp_vled        = '0;
    hs_errors       = 0;
    last_rd         = '0;
    table_ready     = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk_main_a0);
    #2;
    rst_main_n_sync = 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      apply_row(i);
    end
    repeat (4) @(posedge clk_main_a0);
    end_run(1'b0);
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_ready);
    repeat (n_rows * 40 + 200) @(posedge clk_main_a0);
    $display("Watchdog expired before the stimulus table finished");
    end_run(1'b1);
  end

endmodule
